//--- mldsa_pwm_config.svh
// shared constants for the masked PWM unit, included by the package and every RTL module
`ifndef MLDSA_PWM_CONFIG_SVH
`define MLDSA_PWM_CONFIG_SVH

// modulus q and share width
`define PWM_Q 23'd8380417
`define PWM_WIDTH 23

// pipeline depths
`define PWM_MUL_LATENCY 4
`define PWM_ADD_LATENCY 1
`define PWM_LATENCY (`PWM_MUL_LATENCY + `PWM_ADD_LATENCY)

// fresh mask words per cycle, one for the multiplier, one for the adder
`define PWM_RND_WORDS 2

// wishbone word address map
`define PWM_ADDR_WIDTH 4
`define PWM_ADDR_U0 4'd0
`define PWM_ADDR_U1 4'd1
`define PWM_ADDR_V0 4'd2
`define PWM_ADDR_V1 4'd3
`define PWM_ADDR_W0 4'd4
`define PWM_ADDR_W1 4'd5
`define PWM_ADDR_CTRL 4'd6
`define PWM_ADDR_STATUS 4'd7
`define PWM_ADDR_R0 4'd8
`define PWM_ADDR_R1 4'd9

// control and status bit positions
`define PWM_CTRL_START 0
`define PWM_CTRL_ACC 1
`define PWM_CTRL_ZERO 2
`define PWM_STAT_BUSY 0
`define PWM_STAT_DONE 1

`endif

//--- masked_pwm_pkg.sv
// types and modular helpers for the masked PWM unit, referenced by scoped name
`default_nettype none
`include "mldsa_pwm_config.svh"

package masked_pwm_pkg;

    // coefficient as two arithmetic shares, index 0 is share 0
    typedef logic [1:0][`PWM_WIDTH-1:0] share_t;

    // register map
    typedef enum logic [`PWM_ADDR_WIDTH-1:0] {
        U0     = `PWM_ADDR_U0,
        U1     = `PWM_ADDR_U1,
        V0     = `PWM_ADDR_V0,
        V1     = `PWM_ADDR_V1,
        W0     = `PWM_ADDR_W0,
        W1     = `PWM_ADDR_W1,
        CTRL   = `PWM_ADDR_CTRL,
        STATUS = `PWM_ADDR_STATUS,
        R0     = `PWM_ADDR_R0,
        R1     = `PWM_ADDR_R1
    } pwm_reg_e;

    // single-cycle ack handshake
    typedef enum logic {
        IDLE = 1'b0,
        ACK  = 1'b1
    } wb_state_e;

    // a + b mod q, both inputs already below q
    function automatic logic [`PWM_WIDTH-1:0] add_mod(input logic [`PWM_WIDTH-1:0] a,
                                                      input logic [`PWM_WIDTH-1:0] b);
        logic [`PWM_WIDTH:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= {1'b0, `PWM_Q}) begin
            s = s - {1'b0, `PWM_Q};
        end
        return s[`PWM_WIDTH-1:0];
    endfunction

    // a - b mod q, borrow bit tells when to add q back
    function automatic logic [`PWM_WIDTH-1:0] sub_mod(input logic [`PWM_WIDTH-1:0] a,
                                                      input logic [`PWM_WIDTH-1:0] b);
        logic [`PWM_WIDTH:0] d;
        d = {1'b0, a} - {1'b0, b};
        if (d[`PWM_WIDTH]) begin
            d = d + {1'b0, `PWM_Q};
        end
        return d[`PWM_WIDTH-1:0];
    endfunction

endpackage

`default_nettype wire

//--- pwm_req_if.sv
// request and response bundle between the register block and the PWM datapath
`timescale 1ns/10ps
`default_nettype none

interface pwm_req_if;

    // request side, one item per valid cycle, no ready
    logic                   valid;
    logic                   zeroize;
    masked_pwm_pkg::share_t u;
    masked_pwm_pkg::share_t v;
    masked_pwm_pkg::share_t w;

    // response side, fixed latency after valid
    logic                   res_valid;
    masked_pwm_pkg::share_t res;

    // register block
    modport master (output valid, zeroize, u, v, w, input res_valid, res);

    // datapath
    modport slave (input valid, zeroize, u, v, w, output res_valid, res);

endinterface

`default_nettype wire

//--- mask_rng.sv
// xorshift mask source for simulation, gives fresh words below q every cycle
`timescale 1ns/10ps
`default_nettype none
`include "mldsa_pwm_config.svh"

module mask_rng (
    input  logic                                      clk,
    input  logic                                      reset_n,
    output logic [`PWM_RND_WORDS-1:0][`PWM_WIDTH-1:0] rnd
);

    // any nonzero seed works, zero would lock the generator
    localparam logic [31:0] SEED = 32'h6b8b_4567;

    logic [31:0]                    state_q;
    logic [`PWM_RND_WORDS:0][31:0]  chain;

    // one xorshift32 step
    function automatic logic [31:0] xs32(input logic [31:0] x);
        logic [31:0] t;
        t = x ^ (x << 13);
        t = t ^ (t >> 17);
        t = t ^ (t << 5);
        return t;
    endfunction

    // chained steps so every word in a cycle is distinct
    always_comb begin
        chain[0] = state_q;
        for (int i = 0; i < `PWM_RND_WORDS; i++) begin
            chain[i+1] = xs32(chain[i]);
            // low bits are below 2q, one subtraction folds them
            rnd[i] = (chain[i+1][`PWM_WIDTH-1:0] >= `PWM_Q) ?
                     chain[i+1][`PWM_WIDTH-1:0] - `PWM_Q : chain[i+1][`PWM_WIDTH-1:0];
        end
    end

    // advances every cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= SEED;
        end else begin
            state_q <= chain[`PWM_RND_WORDS];
        end
    end

endmodule

`default_nettype wire

//--- masked_modmul.sv
// four-stage two-share modular multiplier with Barrett reduction and mask refresh
`timescale 1ns/10ps
`default_nettype none
`include "mldsa_pwm_config.svh"

module masked_modmul (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize,
    input  masked_pwm_pkg::share_t u,
    input  masked_pwm_pkg::share_t v,
    input  logic [`PWM_WIDTH-1:0]  rnd,
    output masked_pwm_pkg::share_t res
);

    localparam int W  = `PWM_WIDTH;
    // cross product
    localparam int PW = 2 * W;
    // sum of two cross products, below 2q^2 < 2^SW
    localparam int SW = PW + 1;
    // barrett constant floor(2^SW / q) needs W+2 bits
    localparam int MW = W + 2;
    localparam int EW = SW + MW;
    localparam logic [MW-1:0] MU = MW'((64'd1 << SW) / `PWM_Q);

    // stage 1 products: u0v0, u0v1, u1v0, u1v1
    logic [3:0][PW-1:0]     prod_q;
    // stage 2 per-share sums
    logic [1:0][SW-1:0]     sum_q;
    // stage 3 reduced shares
    masked_pwm_pkg::share_t red_q;

    // barrett scratch
    logic [1:0][EW-1:0]     est;
    logic [1:0][SW-1:0]     rem_full;
    logic [1:0][W:0]        rem;
    masked_pwm_pkg::share_t red_d;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            // quotient estimate is at most one low
            est[i]      = EW'(sum_q[i]) * EW'(MU);
            rem_full[i] = sum_q[i] - SW'(est[i][EW-1:SW]) * SW'(`PWM_Q);
            // remainder below 2q
            rem[i]      = rem_full[i][W:0];
            red_d[i]    = (rem[i] >= {1'b0, `PWM_Q}) ?
                          W'(rem[i] - {1'b0, `PWM_Q}) : rem[i][W-1:0];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q <= '0;
            sum_q  <= '0;
            red_q  <= '0;
            res    <= '0;
        end else if (zeroize) begin
            prod_q <= '0;
            sum_q  <= '0;
            red_q  <= '0;
            res    <= '0;
        end else begin
            // stage 1
            prod_q[0] <= u[0] * v[0];
            prod_q[1] <= u[0] * v[1];
            prod_q[2] <= u[1] * v[0];
            prod_q[3] <= u[1] * v[1];
            // stage 2, share i gets u_i times (v0 + v1)
            sum_q[0]  <= SW'(prod_q[0]) + SW'(prod_q[1]);
            sum_q[1]  <= SW'(prod_q[2]) + SW'(prod_q[3]);
            // stage 3
            red_q     <= red_d;
            // stage 4, refresh keeps the share sum unchanged
            res[0]    <= masked_pwm_pkg::add_mod(red_q[0], rnd);
            res[1]    <= masked_pwm_pkg::sub_mod(red_q[1], rnd);
        end
    end

endmodule

`default_nettype wire

//--- masked_modadd.sv
// registered two-share modular adder with mask refresh, one cycle latency
`timescale 1ns/10ps
`default_nettype none
`include "mldsa_pwm_config.svh"

module masked_modadd (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize,
    input  masked_pwm_pkg::share_t u,
    input  masked_pwm_pkg::share_t v,
    input  logic [`PWM_WIDTH-1:0]  rnd,
    output masked_pwm_pkg::share_t res
);

    // share-wise sums before refresh
    masked_pwm_pkg::share_t sum;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            sum[i] = masked_pwm_pkg::add_mod(u[i], v[i]);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res <= '0;
        end else if (zeroize) begin
            res <= '0;
        end else begin
            // +rnd on share 0, -rnd on share 1
            res[0] <= masked_pwm_pkg::add_mod(sum[0], rnd);
            res[1] <= masked_pwm_pkg::sub_mod(sum[1], rnd);
        end
    end

endmodule

`default_nettype wire

//--- masked_pwm.sv
// masked pointwise multiply datapath, computes u*v + w on shares at fixed latency
`timescale 1ns/10ps
`default_nettype none
`include "mldsa_pwm_config.svh"

module masked_pwm (
    input  logic                                      clk,
    input  logic                                      reset_n,
    pwm_req_if.slave                                  req,
    input  logic [`PWM_RND_WORDS-1:0][`PWM_WIDTH-1:0] rnd
);

    // product shares, MUL_LATENCY after the request
    masked_pwm_pkg::share_t                            mul_res;
    // w held back so it meets its own product
    masked_pwm_pkg::share_t [`PWM_MUL_LATENCY-1:0]     w_dly;
    // valid tracks the item down the whole pipe
    logic [`PWM_LATENCY-1:0]                           vld_sr;
    masked_pwm_pkg::share_t                            add_res;

    masked_modmul u_mul (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (req.zeroize),
        .u       (req.u),
        .v       (req.v),
        .rnd     (rnd[0]),
        .res     (mul_res)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            w_dly  <= '0;
            vld_sr <= '0;
        end else if (req.zeroize) begin
            w_dly  <= '0;
            vld_sr <= '0;
        end else begin
            // w sampled every cycle, only the valid ones matter
            w_dly[0] <= req.w;
            for (int i = 1; i < `PWM_MUL_LATENCY; i++) begin
                w_dly[i] <= w_dly[i-1];
            end
            vld_sr <= {vld_sr[`PWM_LATENCY-2:0], req.valid};
        end
    end

    // accumulate stage, zero w gives plain pwm
    masked_modadd u_add (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (req.zeroize),
        .u       (mul_res),
        .v       (w_dly[`PWM_MUL_LATENCY-1]),
        .rnd     (rnd[1]),
        .res     (add_res)
    );

    assign req.res       = add_res;
    assign req.res_valid = vld_sr[`PWM_LATENCY-1];

endmodule

`default_nettype wire

//--- pwm_wb_regs.sv
// wishbone classic register block, holds operand shares, starts the datapath, captures results
`timescale 1ns/10ps
`default_nettype none
`include "mldsa_pwm_config.svh"

module pwm_wb_regs (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  logic [`PWM_ADDR_WIDTH-1:0] adr,
    input  logic [31:0]                dat_w,
    output logic [31:0]                dat_r,
    output logic                       ack,
    pwm_req_if.master                  req
);

    localparam int W   = `PWM_WIDTH;
    localparam int PAD = 32 - W;

    masked_pwm_pkg::wb_state_e state_q;
    masked_pwm_pkg::pwm_reg_e  reg_sel;
    masked_pwm_pkg::share_t    u_q;
    masked_pwm_pkg::share_t    v_q;
    masked_pwm_pkg::share_t    w_q;
    masked_pwm_pkg::share_t    r_q;
    logic                      acc_q;
    logic                      busy_q;
    logic                      done_q;
    logic                      valid_q;
    logic                      zero_q;
    logic                      wr_en;
    logic                      ctrl_wr;
    logic                      zero_req;
    logic                      start;
    logic [31:0]               rd_data;

    assign reg_sel  = masked_pwm_pkg::pwm_reg_e'(adr);
    assign ack      = (state_q == masked_pwm_pkg::ACK);
    // writes land at the end of the ack cycle
    assign wr_en    = ack && we;
    assign ctrl_wr  = wr_en && (reg_sel == masked_pwm_pkg::CTRL);
    assign zero_req = ctrl_wr && dat_w[`PWM_CTRL_ZERO];
    // zeroize wins, start while busy dropped
    assign start    = ctrl_wr && dat_w[`PWM_CTRL_START] && !zero_req && !busy_q;

    // ack one cycle after cyc & stb, never stalls
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= masked_pwm_pkg::IDLE;
        end else begin
            case (state_q)
                masked_pwm_pkg::IDLE: if (cyc && stb) state_q <= masked_pwm_pkg::ACK;
                default:              state_q <= masked_pwm_pkg::IDLE;
            endcase
        end
    end

    // operand shares and accumulate mode
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            u_q   <= '0;
            v_q   <= '0;
            w_q   <= '0;
            acc_q <= 1'b0;
        end else if (wr_en) begin
            case (reg_sel)
                masked_pwm_pkg::U0:   u_q[0] <= dat_w[W-1:0];
                masked_pwm_pkg::U1:   u_q[1] <= dat_w[W-1:0];
                masked_pwm_pkg::V0:   v_q[0] <= dat_w[W-1:0];
                masked_pwm_pkg::V1:   v_q[1] <= dat_w[W-1:0];
                masked_pwm_pkg::W0:   w_q[0] <= dat_w[W-1:0];
                masked_pwm_pkg::W1:   w_q[1] <= dat_w[W-1:0];
                masked_pwm_pkg::CTRL: acc_q  <= dat_w[`PWM_CTRL_ACC];
                default: ;
            endcase
        end
    end

    // start, zeroize, busy/done and result capture
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
            zero_q  <= 1'b0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            r_q     <= '0;
        end else begin
            valid_q <= start;
            zero_q  <= zero_req;
            if (zero_q) begin
                // pipe is flushed, nothing will come back
                busy_q <= 1'b0;
                done_q <= 1'b0;
                r_q    <= '0;
            end else if (start) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end else if (req.res_valid) begin
                r_q    <= req.res;
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    // read mux, unmapped reads zero
    always_comb begin
        rd_data = '0;
        case (reg_sel)
            masked_pwm_pkg::U0:     rd_data = {{PAD{1'b0}}, u_q[0]};
            masked_pwm_pkg::U1:     rd_data = {{PAD{1'b0}}, u_q[1]};
            masked_pwm_pkg::V0:     rd_data = {{PAD{1'b0}}, v_q[0]};
            masked_pwm_pkg::V1:     rd_data = {{PAD{1'b0}}, v_q[1]};
            masked_pwm_pkg::W0:     rd_data = {{PAD{1'b0}}, w_q[0]};
            masked_pwm_pkg::W1:     rd_data = {{PAD{1'b0}}, w_q[1]};
            masked_pwm_pkg::CTRL:   rd_data[`PWM_CTRL_ACC] = acc_q;
            masked_pwm_pkg::STATUS: begin
                rd_data[`PWM_STAT_BUSY] = busy_q;
                rd_data[`PWM_STAT_DONE] = done_q;
            end
            masked_pwm_pkg::R0:     rd_data = {{PAD{1'b0}}, r_q[0]};
            masked_pwm_pkg::R1:     rd_data = {{PAD{1'b0}}, r_q[1]};
            default:                rd_data = '0;
        endcase
    end

    // read data latched as the cycle is accepted, valid with ack
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            dat_r <= '0;
        end else if ((state_q == masked_pwm_pkg::IDLE) && cyc && stb && !we) begin
            dat_r <= rd_data;
        end
    end

    // request to the datapath, w gated by accumulate
    assign req.valid   = valid_q;
    assign req.zeroize = zero_q;
    assign req.u       = u_q;
    assign req.v       = v_q;
    assign req.w       = acc_q ? w_q : '0;

endmodule

`default_nettype wire

//--- masked_pwm_top.sv
// top level of the masked PWM unit, wishbone slave on plain ports
`timescale 1ns/10ps
`default_nettype none
`include "mldsa_pwm_config.svh"

module masked_pwm_top (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  logic [`PWM_ADDR_WIDTH-1:0] adr,
    input  logic [31:0]                dat_w,
    output logic [31:0]                dat_r,
    output logic                       ack
);

    // fresh masks for both arithmetic stages
    logic [`PWM_RND_WORDS-1:0][`PWM_WIDTH-1:0] rnd;

    pwm_req_if req_bus ();

    pwm_wb_regs u_regs (
        .clk     (clk),
        .reset_n (reset_n),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .adr     (adr),
        .dat_w   (dat_w),
        .dat_r   (dat_r),
        .ack     (ack),
        .req     (req_bus.master)
    );

    masked_pwm u_pwm (
        .clk     (clk),
        .reset_n (reset_n),
        .req     (req_bus.slave),
        .rnd     (rnd)
    );

    mask_rng u_rng (
        .clk     (clk),
        .reset_n (reset_n),
        .rnd     (rnd)
    );

endmodule

`default_nettype wire

//--- tb_masked_pwm.sv
// self-checking testbench for the masked PWM unit that applies a case table over the wishbone port
`timescale 1ns/10ps
`default_nettype none
`include "mldsa_pwm_config.svh"

module tb_masked_pwm;

    localparam int NUM_FIXED   = 10;
    localparam int NUM_RAND    = 6;
    localparam int NUM_ENTRIES = NUM_FIXED + NUM_RAND;
    localparam int CYCLE_LIMIT = 60 * NUM_ENTRIES + 200;
    localparam int W           = `PWM_WIDTH;
    localparam logic [63:0]  Q   = 64'(`PWM_Q);
    localparam logic [W-1:0] QM1 = W'(`PWM_Q - 23'd1);

    // one case in unmasked values
    typedef struct packed {
        logic [W-1:0] u;
        logic [W-1:0] v;
        logic [W-1:0] w;
        logic         acc;
        logic         zero;
    } entry_t;

    logic        clk;
    logic        reset_n;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        ack;

    entry_t      entries [NUM_ENTRIES];
    logic [31:0] rng_state;
    int          n_mismatch;
    int          n_other;
    int          cycle_cnt;

    masked_pwm_top u_dut (
        .clk     (clk),
        .reset_n (reset_n),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .adr     (adr),
        .dat_w   (dat_w),
        .dat_r   (dat_r),
        .ack     (ack)
    );

    always #4 clk = ~clk;

    // run length guard
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Error: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] t;
        t = x ^ (x << 13);
        t = t ^ (t >> 17);
        t = t ^ (t << 5);
        return t;
    endfunction

    // uniform-ish value below q
    function automatic logic [W-1:0] rand_mod_q();
        rng_state = xorshift32(rng_state);
        return W'(rng_state % 32'(`PWM_Q));
    endfunction

    function automatic entry_t make_entry(input logic [W-1:0] u, input logic [W-1:0] v,
                                          input logic [W-1:0] w, input logic acc,
                                          input logic zero);
        entry_t e;
        e.u    = u;
        e.v    = v;
        e.w    = w;
        e.acc  = acc;
        e.zero = zero;
        return e;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        n_mismatch++;
        $display("Mismatch at %t: %s expected 0x%08h, got 0x%08h", $time, name, expected, actual);
    endtask

    // fixed edge cases first and random ones after
    task automatic build_table();
        int           i;
        logic [W-1:0] ru;
        logic [W-1:0] rv;
        logic [W-1:0] rw;
        entries[0] = make_entry(23'd0, 23'd0, 23'd0, 1'b0, 1'b0);
        entries[1] = make_entry(23'd1, 23'd1, 23'd0, 1'b0, 1'b0);
        entries[2] = make_entry(QM1, QM1, 23'd0, 1'b0, 1'b0);
        entries[3] = make_entry(QM1, 23'd1, 23'd0, 1'b0, 1'b0);
        // accumulate and then the same w with accumulate clear
        entries[4] = make_entry(23'd1234567, 23'd7654321, 23'd4444444, 1'b1, 1'b0);
        entries[5] = make_entry(23'd1234567, 23'd7654321, 23'd4444444, 1'b0, 1'b0);
        // zeroize ahead of an identical pair for the masking check
        entries[6] = make_entry(23'd8000000, 23'd3, QM1, 1'b1, 1'b1);
        entries[7] = make_entry(23'd8000000, 23'd3, QM1, 1'b1, 1'b0);
        entries[8] = make_entry(QM1, QM1, QM1, 1'b1, 1'b0);
        entries[9] = make_entry(23'd2, 23'd0, 23'd5, 1'b1, 1'b1);
        for (i = NUM_FIXED; i < NUM_ENTRIES; i++) begin
            ru = rand_mod_q();
            rv = rand_mod_q();
            rw = rand_mod_q();
            // accumulate picked by a state bit
            entries[i] = make_entry(ru, rv, rw, rng_state[7], 1'b0);
        end
    endtask

    // single wishbone write with stb dropped once ack is seen
    task automatic bus_write(input logic [3:0] addr, input logic [31:0] data);
        bit got_ack;
        int n;
        got_ack = 1'b0;
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = addr;
        dat_w = data;
        for (n = 0; n < 4 && !got_ack; n++) begin
            @(negedge clk);
            got_ack = ack;
        end
        if (!got_ack) begin
            n_other++;
            $display("Error at %t: no ack within 4 cycles on write to address %0d", $time, addr);
        end
        // we and dat_w held for the commit edge
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    task automatic bus_read(input logic [3:0] addr, output logic [31:0] data);
        bit got_ack;
        int n;
        got_ack = 1'b0;
        @(negedge clk);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = addr;
        for (n = 0; n < 4 && !got_ack; n++) begin
            @(negedge clk);
            got_ack = ack;
        end
        if (!got_ack) begin
            n_other++;
            $display("Error at %t: no ack within 4 cycles on read from address %0d", $time, addr);
        end
        data = dat_r;
        cyc  = 1'b0;
        stb  = 1'b0;
    endtask

    // every register reads zero out of reset
    task automatic check_reset_state();
        logic [3:0]               addr;
        logic [31:0]              rd;
        masked_pwm_pkg::pwm_reg_e sel;
        for (addr = 4'd0; addr <= 4'd9; addr++) begin
            sel = masked_pwm_pkg::pwm_reg_e'(addr);
            bus_read(addr, rd);
            if (rd != 32'd0) report_mismatch(sel.name(), 32'd0, rd);
        end
    endtask

    // random split into two shares that are written and read back
    task automatic load_share(input logic [3:0] addr0, input logic [W-1:0] value,
                              input string nm);
        logic [63:0] s0;
        logic [63:0] s1;
        logic [31:0] rd;
        s0 = 64'(rand_mod_q());
        s1 = (64'(value) + Q - s0) % Q;
        bus_write(addr0, 32'(s0));
        bus_write(addr0 + 4'd1, 32'(s1));
        bus_read(addr0, rd);
        if (rd != 32'(s0)) report_mismatch({nm, "0"}, 32'(s0), rd);
        bus_read(addr0 + 4'd1, rd);
        if (rd != 32'(s1)) report_mismatch({nm, "1"}, 32'(s1), rd);
    endtask

    task automatic wait_done();
        logic [31:0] status;
        bit          done;
        int          polls;
        done  = 1'b0;
        polls = 0;
        while (!done && polls < 10) begin
            bus_read(masked_pwm_pkg::STATUS, status);
            done = status[`PWM_STAT_DONE];
            polls++;
        end
        if (!done) begin
            n_other++;
            $display("Error at %t: done not set after 10 STATUS polls", $time);
        end else if (status != 32'h2) begin
            report_mismatch("STATUS", 32'h2, status);
        end
    endtask

    // results read back and checked against (u*v + acc*w) mod q
    task automatic read_result(input logic [63:0] expected, output logic [31:0] r0,
                               output logic [31:0] r1);
        logic [63:0] sum;
        bus_read(masked_pwm_pkg::R0, r0);
        bus_read(masked_pwm_pkg::R1, r1);
        if (64'(r0) >= Q || 64'(r1) >= Q) begin
            n_other++;
            $display("Error at %t: result share not below q (R0 0x%h, R1 0x%h)", $time, r0, r1);
        end
        sum = (64'(r0) + 64'(r1)) % Q;
        if (sum != expected) report_mismatch("R0+R1 mod q", 32'(expected), 32'(sum));
    endtask

    task automatic run_entry(input entry_t e, input bit keep_shares, output logic [31:0] r0,
                             output logic [31:0] r1);
        logic [31:0] rd;
        logic [63:0] expected;
        if (e.zero) begin
            bus_write(masked_pwm_pkg::CTRL, 32'h4);
            // flush lands one cycle after the ack
            @(negedge clk);
            bus_read(masked_pwm_pkg::STATUS, rd);
            if (rd != 32'd0) report_mismatch("STATUS after zeroize", 32'd0, rd);
            bus_read(masked_pwm_pkg::R0, rd);
            if (rd != 32'd0) report_mismatch("R0 after zeroize", 32'd0, rd);
            bus_read(masked_pwm_pkg::R1, rd);
            if (rd != 32'd0) report_mismatch("R1 after zeroize", 32'd0, rd);
        end
        // a repeat keeps the shares already in the registers
        if (!keep_shares) begin
            load_share(masked_pwm_pkg::U0, e.u, "U");
            load_share(masked_pwm_pkg::V0, e.v, "V");
            load_share(masked_pwm_pkg::W0, e.w, "W");
        end
        bus_write(masked_pwm_pkg::CTRL, {30'd0, e.acc, 1'b1});
        // old done must be gone and busy up
        bus_read(masked_pwm_pkg::STATUS, rd);
        if (rd != 32'h1) report_mismatch("STATUS after start", 32'h1, rd);
        wait_done();
        expected = (64'(e.u) * 64'(e.v) + (e.acc ? 64'(e.w) : 64'd0)) % Q;
        read_result(expected, r0, r1);
    endtask

    // second start with accumulate set lands while busy so the result stays u*v
    task automatic start_while_busy();
        logic [31:0] rd;
        logic [31:0] r0;
        logic [31:0] r1;
        load_share(masked_pwm_pkg::U0, 23'd777777, "U");
        load_share(masked_pwm_pkg::V0, 23'd999, "V");
        load_share(masked_pwm_pkg::W0, 23'd55555, "W");
        bus_write(masked_pwm_pkg::CTRL, 32'h1);
        bus_write(masked_pwm_pkg::CTRL, 32'h3);
        wait_done();
        // room for a stray second result to show up
        repeat (8) @(negedge clk);
        bus_read(masked_pwm_pkg::STATUS, rd);
        if (rd != 32'h2) report_mismatch("STATUS after ignored start", 32'h2, rd);
        read_result((64'd777777 * 64'd999) % Q, r0, r1);
    endtask

    initial begin
        int          i;
        bit          same;
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] prev_r0;
        logic [31:0] prev_r1;
        $timeformat(-9, 2, " ns", 10);
        clk        = 1'b0;
        reset_n    = 1'b0;
        cyc        = 1'b0;
        stb        = 1'b0;
        we         = 1'b0;
        adr        = 4'd0;
        dat_w      = 32'd0;
        n_mismatch = 0;
        n_other    = 0;
        cycle_cnt  = 0;
        prev_r0    = 32'd0;
        prev_r1    = 32'd0;
        rng_state  = 32'he3e1_f178;
        build_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        check_reset_state();
        for (i = 0; i < NUM_ENTRIES; i++) begin
            same = (i > 0) && (entries[i].u == entries[i-1].u) &&
                   (entries[i].v == entries[i-1].v) && (entries[i].w == entries[i-1].w) &&
                   (entries[i].acc == entries[i-1].acc);
            run_entry(entries[i], same, r0, r1);
            // identical operand shares give the same sum from fresh masks
            if (same) begin
                if (r0 == prev_r0) begin
                    n_other++;
                    $display("Error at %t: R0 repeated across identical runs of entry %0d",
                             $time, i);
                end
                if ((64'(r0) + 64'(r1)) % Q != (64'(prev_r0) + 64'(prev_r1)) % Q) begin
                    n_other++;
                    $display("Error at %t: share sum changed across identical runs", $time);
                end
            end
            prev_r0 = r0;
            prev_r1 = r1;
        end
        start_while_busy();
        $display("mismatches %0d, other errors %0d", n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
masked_pwm_pkg.sv
pwm_req_if.sv
mask_rng.sv
masked_modmul.sv
masked_modadd.sv
masked_pwm.sv
pwm_wb_regs.sv
masked_pwm_top.sv
tb_masked_pwm.sv

//--- run.sh
#!/usr/bin/env bash
# build the masked PWM testbench with Verilator, run it, decide pass or fail from the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=sim_masked_pwm

verilator --binary --timing -f flist.f --top-module tb_masked_pwm -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
    echo "run.sh: verilator build failed"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "run.sh: simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
    echo "run.sh: simulation passed"
    exit 0
else
    echo "run.sh: pass message not found in $LOG"
    exit 1
fi
